/* Bender.yml */
package:
  name: mlp_accel

sources:
  - common/mlp_pkg.sv
  - logic/mlp_ram.sv
  - logic/mlp_regs.sv
  - engine/mlp_sequencer.sv
  - engine/mlp_mac.sv
  - engine/mlp_writeback.sv
  - logic/mlp_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mlp_tb.sv

/* common/mlp_pkg.sv */
package mlp_pkg;

  localparam int data_w        = 8;
  localparam int weight_w      = 16;
  localparam int acc_w         = 32;
  localparam int lut_addr_w    = 12;
  localparam int data_addr_w   = 10;
  localparam int weight_addr_w = 12;
  localparam int count_w       = 8;

  // data memory banks, the bank sits above an 8-bit index
  localparam logic [1:0] bank_input  = 2'd0;
  localparam logic [1:0] bank_hidden = 2'd1;
  localparam logic [1:0] bank_output = 2'd2;

  localparam logic [weight_addr_w-1:0] layer_hidden_base = 12'h000;
  localparam logic [weight_addr_w-1:0] layer_output_base = 12'h800;

  // idle cycles between layers so hidden results land before they are read
  localparam int drain_gap = 6;

  localparam logic [3:0] region_regs   = 4'h0;
  localparam logic [3:0] region_data   = 4'h1;
  localparam logic [3:0] region_lut    = 4'h4;
  localparam logic [3:0] region_weight = 4'h8;

  localparam logic [7:0] reg_control = 8'h04;
  localparam logic [7:0] reg_status  = 8'h08;
  localparam logic [7:0] reg_inputs  = 8'h10;
  localparam logic [7:0] reg_hidden  = 8'h14;
  localparam logic [7:0] reg_outputs = 8'h18;

  localparam int ctrl_load_bit  = 0;
  localparam int ctrl_start_bit = 1;

  typedef union packed {
    struct packed {
      logic [3:0] region;
      logic [3:0] unused;
      logic [7:0] offset;
    } regs;
    struct packed {
      logic [3:0] region;
      logic [1:0] bank;
      logic [1:0] pad;
      logic [7:0] index;
    } mem;
  } bus_addr_u;

  typedef struct packed {
    logic [count_w-1:0] num_inputs;
    logic [count_w-1:0] num_hidden;
    logic [count_w-1:0] num_outputs;
  } mlp_cfg_t;

  typedef struct packed {
    logic valid;
    logic first;
    logic last;
    logic layer;
  } elem_tag_t;

  typedef struct packed {
    logic                  valid;
    logic                  layer;
    logic [lut_addr_w-1:0] index;
  } lut_req_t;

  // sized for the widest memory, each memory takes the low bits it needs
  typedef struct packed {
    logic                     we;
    logic [weight_addr_w-1:0] addr;
    logic [weight_w-1:0]      data;
  } ram_wr_t;

endpackage

/* engine/mlp_mac.sv */
`timescale 1ns/100ps

module mlp_mac (
  input  logic                            clock,
  input  logic                            rst_n,
  input  mlp_pkg::elem_tag_t              tag,
  input  logic [mlp_pkg::data_w-1:0]      data,
  input  logic [mlp_pkg::weight_w-1:0]    weight,
  output mlp_pkg::lut_req_t               lut_req
);

  mlp_pkg::elem_tag_t                                 tag_d1;
  mlp_pkg::elem_tag_t                                 tag_d2;
  mlp_pkg::elem_tag_t                                 tag_d3;
  logic signed [mlp_pkg::data_w+mlp_pkg::weight_w-1:0] prod;
  logic signed [mlp_pkg::acc_w-1:0]                   sum;
  logic [mlp_pkg::lut_addr_w-1:0]                     index;
  logic                                               pos_sat;
  logic                                               neg_sat;

  // the index covers an 18-bit signed range, anything outside clips
  assign pos_sat = !sum[31] && (|sum[30:17]);
  assign neg_sat = sum[31] && !(&sum[30:17]);
  assign index   = pos_sat ? 12'h7FF : (neg_sat ? 12'h800 : {sum[31], sum[16:6]});

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tag_d1  <= '0;
      tag_d2  <= '0;
      tag_d3  <= '0;
      lut_req <= '0;
    end else begin
      tag_d1        <= tag;
      tag_d2        <= tag_d1;
      tag_d3        <= tag_d2;
      lut_req.valid <= tag_d3.valid && tag_d3.last;
      lut_req.layer <= tag_d3.layer;
      lut_req.index <= index;
    end
  end

  always_ff @(posedge clock) begin
    prod <= $signed(data) * $signed(weight);
    if (tag_d2.valid) begin
      if (tag_d2.first) begin
        sum <= prod;
      end else begin
        sum <= sum + prod;
      end
    end
  end

endmodule

/* engine/mlp_sequencer.sv */
`timescale 1ns/100ps

module mlp_sequencer (
  input  logic                              clock,
  input  logic                              rst_n,
  input  mlp_pkg::mlp_cfg_t                 cfg,
  input  logic                              start,
  input  logic                              done,
  output logic [mlp_pkg::data_addr_w-1:0]   data_addr,
  output logic [mlp_pkg::weight_addr_w-1:0] weight_addr,
  output mlp_pkg::elem_tag_t                tag
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_run   = 2'd1;
  localparam logic [1:0] st_drain = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic [1:0]                        state;
  logic                              layer;
  logic [mlp_pkg::count_w-1:0]       elem;
  logic [mlp_pkg::count_w-1:0]       neuron;
  logic [mlp_pkg::count_w-1:0]       n_elem;
  logic [mlp_pkg::count_w-1:0]       n_neuron;
  logic [2:0]                        gap;
  logic [mlp_pkg::weight_addr_w-1:0] weight_ptr;
  logic                              last_elem;
  logic                              last_neuron;

  // the output layer consumes hidden values and produces num_outputs neurons
  assign n_elem      = layer ? cfg.num_hidden : cfg.num_inputs;
  assign n_neuron    = layer ? cfg.num_outputs : cfg.num_hidden;
  assign last_elem   = elem == n_elem - 1'b1;
  assign last_neuron = neuron == n_neuron - 1'b1;

  assign data_addr   = {layer ? mlp_pkg::bank_hidden : mlp_pkg::bank_input, elem};
  assign weight_addr = weight_ptr;

  always_comb begin
    tag.valid = state == st_run;
    tag.first = elem == '0;
    tag.last  = last_elem;
    tag.layer = layer;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      layer      <= 1'b0;
      elem       <= '0;
      neuron     <= '0;
      gap        <= '0;
      weight_ptr <= mlp_pkg::layer_hidden_base;
    end else if (!start) begin
      state      <= st_idle;
      layer      <= 1'b0;
      elem       <= '0;
      neuron     <= '0;
      gap        <= '0;
      weight_ptr <= mlp_pkg::layer_hidden_base;
    end else begin
      case (state)
        st_idle: begin
          if (!done) begin
            state <= st_run;
          end
        end
        st_run: begin
          // weights of one layer are stored neuron after neuron
          weight_ptr <= weight_ptr + 1'b1;
          if (!last_elem) begin
            elem <= elem + 1'b1;
          end else begin
            elem <= '0;
            if (!last_neuron) begin
              neuron <= neuron + 1'b1;
            end else if (!layer) begin
              state  <= st_drain;
              neuron <= '0;
              gap    <= '0;
            end else begin
              state <= st_stop;
            end
          end
        end
        st_drain: begin
          gap <= gap + 1'b1;
          if (gap == 3'(mlp_pkg::drain_gap - 1)) begin
            state      <= st_run;
            layer      <= 1'b1;
            weight_ptr <= mlp_pkg::layer_output_base;
          end
        end
        default: state <= st_stop;
      endcase
    end
  end

endmodule

/* engine/mlp_writeback.sv */
`timescale 1ns/100ps

module mlp_writeback (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       start,
  input  mlp_pkg::lut_req_t          lut_req,
  input  logic [mlp_pkg::data_w-1:0] lut_data,
  input  mlp_pkg::mlp_cfg_t          cfg,
  output mlp_pkg::ram_wr_t           data_wr,
  output logic                       done
);

  mlp_pkg::lut_req_t           req_d;
  logic [mlp_pkg::count_w-1:0] hid_idx;
  logic [mlp_pkg::count_w-1:0] out_idx;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_d   <= '0;
      hid_idx <= '0;
      out_idx <= '0;
      done    <= 1'b0;
    end else if (!start) begin
      req_d   <= '0;
      hid_idx <= '0;
      out_idx <= '0;
      done    <= 1'b0;
    end else begin
      // one cycle behind the request so the table value has arrived
      req_d <= lut_req;
      if (req_d.valid && req_d.layer) begin
        out_idx <= out_idx + 1'b1;
        if (out_idx == cfg.num_outputs - 1'b1) begin
          done <= 1'b1;
        end
      end else if (req_d.valid) begin
        hid_idx <= hid_idx + 1'b1;
      end
    end
  end

  always_comb begin
    data_wr.we   = req_d.valid;
    data_wr.addr = req_d.layer ? {2'b0, mlp_pkg::bank_output, out_idx}
                               : {2'b0, mlp_pkg::bank_hidden, hid_idx};
    data_wr.data = {8'b0, lut_data};
  end

endmodule

/* logic/mlp_ram.sv */
`timescale 1ns/100ps

module mlp_ram #(
  parameter int width      = 8,
  parameter int depth_log2 = 10
) (
  input  logic                  clock,
  input  mlp_pkg::ram_wr_t      wr,
  input  logic [depth_log2-1:0] rd_addr,
  output logic [width-1:0]      rd_a,
  output logic [width-1:0]      rd_b
);

  logic [width-1:0]      mem [2**depth_log2];
  logic [depth_log2-1:0] wr_addr;

  // port A reads wherever the write port points
  assign wr_addr = wr.addr[depth_log2-1:0];

  always_ff @(posedge clock) begin
    if (wr.we) begin
      mem[wr_addr] <= wr.data[width-1:0];
    end
    rd_a <= mem[wr_addr];
    rd_b <= mem[rd_addr];
  end

endmodule

/* logic/mlp_regs.sv */
`timescale 1ns/100ps

module mlp_regs (
  input  logic                           clock,
  input  logic                           rst_n,
  input  logic [15:0]                    address,
  input  logic [31:0]                    din,
  input  logic                           write,
  input  logic                           read,
  output logic [31:0]                    dout,
  output mlp_pkg::mlp_cfg_t              cfg,
  output logic                           start,
  input  logic                           done,
  input  logic [mlp_pkg::data_w-1:0]     data_rd,
  input  logic [mlp_pkg::data_w-1:0]     lut_rd,
  input  logic [mlp_pkg::weight_w-1:0]   weight_rd,
  input  mlp_pkg::ram_wr_t               engine_wr,
  input  mlp_pkg::lut_req_t              lut_req,
  output mlp_pkg::ram_wr_t               data_wr,
  output mlp_pkg::ram_wr_t               weight_wr,
  output mlp_pkg::ram_wr_t               lut_wr,
  output logic [mlp_pkg::lut_addr_w-1:0] lut_addr
);

  mlp_pkg::bus_addr_u                 bus;
  logic [1:0]                         ctrl;
  logic                               load;
  logic                               reg_sel;
  logic                               data_sel;
  logic                               lut_sel;
  logic                               weight_sel;
  logic                               engine_owns;
  logic [mlp_pkg::data_addr_w-1:0]    bus_data_addr;
  logic [mlp_pkg::weight_addr_w-1:0]  bus_weight_addr;
  logic [mlp_pkg::lut_addr_w-1:0]     bus_lut_addr;

  assign bus   = address;
  assign load  = ctrl[mlp_pkg::ctrl_load_bit];
  assign start = ctrl[mlp_pkg::ctrl_start_bit];

  assign reg_sel    = bus.regs.region == mlp_pkg::region_regs;
  assign data_sel   = bus.mem.region == mlp_pkg::region_data;
  assign lut_sel    = bus.mem.region == mlp_pkg::region_lut;
  assign weight_sel = bus.mem.region[3:1] == mlp_pkg::region_weight[3:1];

  assign bus_data_addr   = {bus.mem.bank, bus.mem.index};
  // the low region bit picks the hidden or the output weight bank
  assign bus_weight_addr = {bus.mem.region[0], bus.mem.bank[0], bus.mem.pad, bus.mem.index};
  assign bus_lut_addr    = {bus.mem.bank, bus.mem.pad, bus.mem.index};

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= '0;
      cfg  <= '0;
    end else if (write && reg_sel) begin
      case (bus.regs.offset)
        mlp_pkg::reg_control: ctrl <= din[1:0];
        mlp_pkg::reg_inputs:  cfg.num_inputs <= din[mlp_pkg::count_w-1:0];
        mlp_pkg::reg_hidden:  cfg.num_hidden <= din[mlp_pkg::count_w-1:0];
        mlp_pkg::reg_outputs: cfg.num_outputs <= din[mlp_pkg::count_w-1:0];
        default: ;
      endcase
    end
  end

  // an idle engine leaves port A on the bus address so results can be read
  assign engine_owns = !load && engine_wr.we;

  always_comb begin
    data_wr.we     = load ? (write && data_sel) : engine_wr.we;
    data_wr.addr   = engine_owns ? engine_wr.addr : {2'b0, bus_data_addr};
    data_wr.data   = engine_owns ? engine_wr.data : {8'b0, din[7:0]};
    weight_wr.we   = load && write && weight_sel;
    weight_wr.addr = bus_weight_addr;
    weight_wr.data = din[15:0];
    lut_wr.we      = load && write && lut_sel;
    lut_wr.addr    = bus_lut_addr;
    lut_wr.data    = {8'b0, din[7:0]};
    lut_addr       = load ? bus_lut_addr : lut_req.index;
  end

  always_comb begin
    dout = '0;
    if (read) begin
      if (reg_sel) begin
        case (bus.regs.offset)
          mlp_pkg::reg_control: dout = {30'b0, ctrl};
          mlp_pkg::reg_status:  dout = {31'b0, done};
          mlp_pkg::reg_inputs:  dout = {24'b0, cfg.num_inputs};
          mlp_pkg::reg_hidden:  dout = {24'b0, cfg.num_hidden};
          mlp_pkg::reg_outputs: dout = {24'b0, cfg.num_outputs};
          default:              dout = '0;
        endcase
      end else if (data_sel) begin
        dout = {24'b0, data_rd};
      end else if (lut_sel) begin
        dout = {24'b0, lut_rd};
      end else if (weight_sel) begin
        dout = {16'b0, weight_rd};
      end
    end
  end

endmodule

/* logic/mlp_top.sv */
`timescale 1ns/100ps

module mlp_top (
  input  logic        clock,
  input  logic        rst_n,
  input  logic [15:0] address,
  input  logic [31:0] din,
  output logic [31:0] dout,
  input  logic        write,
  input  logic        read
);

  mlp_pkg::mlp_cfg_t                 cfg;
  mlp_pkg::ram_wr_t                  data_wr;
  mlp_pkg::ram_wr_t                  weight_wr;
  mlp_pkg::ram_wr_t                  lut_wr;
  mlp_pkg::ram_wr_t                  engine_wr;
  mlp_pkg::lut_req_t                 lut_req;
  mlp_pkg::elem_tag_t                tag;
  logic                              start;
  logic                              done;
  logic [mlp_pkg::lut_addr_w-1:0]    lut_addr;
  logic [mlp_pkg::data_w-1:0]        data_rd;
  logic [mlp_pkg::data_w-1:0]        data_op;
  logic [mlp_pkg::weight_w-1:0]      weight_rd;
  logic [mlp_pkg::weight_w-1:0]      weight_op;
  logic [mlp_pkg::data_w-1:0]        lut_rd;
  logic [mlp_pkg::data_w-1:0]        lut_data;
  logic [mlp_pkg::data_addr_w-1:0]   seq_data_addr;
  logic [mlp_pkg::weight_addr_w-1:0] seq_weight_addr;

  mlp_regs u_regs (
    .clock, .rst_n, .address, .din, .write, .read, .dout,
    .cfg, .start, .done, .data_rd, .lut_rd, .weight_rd,
    .engine_wr, .lut_req, .data_wr, .weight_wr, .lut_wr, .lut_addr
  );

  mlp_ram #(.width(mlp_pkg::data_w), .depth_log2(mlp_pkg::data_addr_w)) u_data_ram (
    .clock, .wr(data_wr), .rd_addr(seq_data_addr), .rd_a(data_rd), .rd_b(data_op)
  );

  mlp_ram #(.width(mlp_pkg::weight_w), .depth_log2(mlp_pkg::weight_addr_w)) u_weight_ram (
    .clock, .wr(weight_wr), .rd_addr(seq_weight_addr), .rd_a(weight_rd), .rd_b(weight_op)
  );

  mlp_ram #(.width(mlp_pkg::data_w), .depth_log2(mlp_pkg::lut_addr_w)) u_lut_ram (
    .clock, .wr(lut_wr), .rd_addr(lut_addr), .rd_a(lut_rd), .rd_b(lut_data)
  );

  mlp_sequencer u_sequencer (
    .clock, .rst_n, .cfg, .start, .done,
    .data_addr(seq_data_addr), .weight_addr(seq_weight_addr), .tag
  );

  mlp_mac u_mac (
    .clock, .rst_n, .tag, .data(data_op), .weight(weight_op), .lut_req
  );

  mlp_writeback u_writeback (
    .clock, .rst_n, .start, .lut_req, .lut_data, .cfg, .data_wr(engine_wr), .done
  );

endmodule

/* project.f */
+incdir+tests
common/mlp_pkg.sv
logic/mlp_ram.sv
logic/mlp_regs.sv
engine/mlp_sequencer.sv
engine/mlp_mac.sv
engine/mlp_writeback.sv
logic/mlp_top.sv
tests/mlp_tb.sv

/* tests/mlp_bus_tasks.svh */
`ifndef mlp_bus_tasks_svh
`define mlp_bus_tasks_svh

function automatic logic [15:0] reg_bus_addr(input logic [7:0] offset);
  return {mlp_pkg::region_regs, 4'h0, offset};
endfunction

function automatic logic [15:0] data_bus_addr(input logic [1:0] bank, input logic [7:0] idx);
  return {mlp_pkg::region_data, bank, 2'b00, idx};
endfunction

// the top weight address bit rides in the low region bit
function automatic logic [15:0] weight_bus_addr(input logic [11:0] waddr);
  return {mlp_pkg::region_weight[3:1], waddr[11], 1'b0, waddr[10:0]};
endfunction

function automatic logic [15:0] lut_bus_addr(input logic [11:0] laddr);
  return {mlp_pkg::region_lut, laddr};
endfunction

task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
  @(posedge clock);
  #1;
  address = addr;
  din     = data;
  write   = 1'b1;
  read    = 1'b0;
  @(posedge clock);
  #1;
  write = 1'b0;
endtask

task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
  @(posedge clock);
  #1;
  address = addr;
  write   = 1'b0;
  read    = 1'b1;
  // memory data is registered and only shows up after the next edge
  @(posedge clock);
  @(negedge clock);
  data = dout;
endtask

`endif

/* tests/mlp_tb.sv */
`timescale 1ns/100ps

module mlp_tb;

  localparam int clk_period  = 100;
  localparam int max_inputs  = 8;
  localparam int max_hidden  = 8;
  localparam int max_outputs = 4;
  localparam int num_runs    = 4;
  // every element of both layers, the gap between them and the pipeline tail
  localparam int run_cycles  = max_inputs * max_hidden + max_hidden * max_outputs
                               + mlp_pkg::drain_gap + 16;
  localparam int load_cycles = 2 * (16 + max_hidden + max_outputs
                               + 2 * (max_inputs + max_inputs * max_hidden
                               + max_hidden * max_outputs));
  localparam int lut_cycles  = 2 * (4096 + 80) + 256;
  localparam int watchdog_ns = (20 * (run_cycles + load_cycles) + lut_cycles) * clk_period;

  logic        clock;
  logic        rst_n;
  logic [15:0] address;
  logic [31:0] din;
  logic [31:0] dout;
  logic        write;
  logic        read;

  logic [7:0]  lut_mem [4096];
  logic [7:0]  in_vals [max_inputs];
  logic [15:0] w_hid [max_inputs * max_hidden];
  logic [15:0] w_out [max_hidden * max_outputs];
  logic [7:0]  hid_exp [max_hidden];
  logic [7:0]  out_exp [max_outputs];

  mlp_top u_dut (
    .clock, .rst_n, .address, .din, .dout, .write, .read
  );

  `include "mlp_bus_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    report_failure($sformatf("timeout: the test did not finish within %0d ns", watchdog_ns));
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input logic [mlp_pkg::data_w-1:0] got,
                            input logic [mlp_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0d ns: %s read 0x%02h, expected 0x%02h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_reg(input string what, input mlp_pkg::mlp_cfg_t got,
                           input mlp_pkg::mlp_cfg_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0d ns: %s read 0x%06h, expected 0x%06h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_word(input string what, input logic [mlp_pkg::weight_w-1:0] got,
                            input logic [mlp_pkg::weight_w-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0d ns: %s read 0x%04h, expected 0x%04h",
                               $time, what, got, exp));
    end
  endtask

  // sums outside the 18-bit signed range clip to the two ends of the table
  function automatic logic [11:0] sat_index(input int acc);
    if (acc > 131071) begin
      return 12'h7FF;
    end else if (acc < -131072) begin
      return 12'h800;
    end
    return 12'(acc >>> 6);
  endfunction

  function automatic logic [15:0] small_weight();
    logic [9:0] r;
    r = 10'($urandom);
    return {{6{r[9]}}, r};
  endfunction

  task automatic compute_model(input mlp_pkg::mlp_cfg_t c);
    int acc;
    for (int n = 0; n < c.num_hidden; n++) begin
      acc = 0;
      for (int e = 0; e < c.num_inputs; e++) begin
        acc = acc + $signed(in_vals[e]) * $signed(w_hid[n * c.num_inputs + e]);
      end
      hid_exp[n] = lut_mem[sat_index(acc)];
    end
    for (int o = 0; o < c.num_outputs; o++) begin
      acc = 0;
      for (int h = 0; h < c.num_hidden; h++) begin
        acc = acc + $signed(hid_exp[h]) * $signed(w_out[o * c.num_hidden + h]);
      end
      out_exp[o] = lut_mem[sat_index(acc)];
    end
  endtask

  task automatic write_counts(input mlp_pkg::mlp_cfg_t c);
    logic [31:0]       rd;
    mlp_pkg::mlp_cfg_t got;
    bus_write(reg_bus_addr(mlp_pkg::reg_inputs), 32'(c.num_inputs));
    bus_write(reg_bus_addr(mlp_pkg::reg_hidden), 32'(c.num_hidden));
    bus_write(reg_bus_addr(mlp_pkg::reg_outputs), 32'(c.num_outputs));
    bus_read(reg_bus_addr(mlp_pkg::reg_inputs), rd);
    got.num_inputs = rd[7:0];
    bus_read(reg_bus_addr(mlp_pkg::reg_hidden), rd);
    got.num_hidden = rd[7:0];
    bus_read(reg_bus_addr(mlp_pkg::reg_outputs), rd);
    got.num_outputs = rd[7:0];
    check_reg("count registers", got, c);
  endtask

  task automatic fill_lut();
    logic [31:0] rd;
    logic [11:0] laddr;
    for (int i = 0; i < 4096; i++) begin
      lut_mem[i] = 8'($urandom);
    end
    // distinct values at both clip points so a wrong clip is visible
    lut_mem[12'h7FF] = 8'h5A;
    lut_mem[12'h800] = 8'hA5;
    for (int i = 0; i < 4096; i++) begin
      bus_write(lut_bus_addr(12'(i)), 32'(lut_mem[i]));
    end
    for (int k = 0; k < 66; k++) begin
      laddr = (k == 0) ? 12'h7FF : ((k == 1) ? 12'h800 : 12'($urandom));
      bus_read(lut_bus_addr(laddr), rd);
      check_data($sformatf("lookup entry 0x%03h", laddr), rd[7:0], lut_mem[laddr]);
    end
  endtask

  task automatic load_run(input mlp_pkg::mlp_cfg_t c, input bit saturate);
    logic [31:0] rd;
    bus_write(reg_bus_addr(mlp_pkg::reg_control), 32'(1) << mlp_pkg::ctrl_load_bit);
    write_counts(c);
    for (int e = 0; e < c.num_inputs; e++) begin
      in_vals[e] = saturate ? 8'h7F : 8'($urandom);
      bus_write(data_bus_addr(mlp_pkg::bank_input, 8'(e)), 32'(in_vals[e]));
    end
    // in the clipping run neuron 0 drives far positive and neuron 1 far negative
    for (int k = 0; k < c.num_inputs * c.num_hidden; k++) begin
      if (saturate) begin
        w_hid[k] = (k < c.num_inputs) ? 16'h7FFF : 16'h8000;
      end else begin
        w_hid[k] = small_weight();
      end
      bus_write(weight_bus_addr(mlp_pkg::layer_hidden_base + 12'(k)), 32'(w_hid[k]));
    end
    for (int k = 0; k < c.num_hidden * c.num_outputs; k++) begin
      w_out[k] = small_weight();
      bus_write(weight_bus_addr(mlp_pkg::layer_output_base + 12'(k)), 32'(w_out[k]));
    end
    for (int e = 0; e < c.num_inputs; e++) begin
      bus_read(data_bus_addr(mlp_pkg::bank_input, 8'(e)), rd);
      check_data($sformatf("input %0d", e), rd[7:0], in_vals[e]);
    end
    for (int k = 0; k < c.num_inputs * c.num_hidden; k++) begin
      bus_read(weight_bus_addr(mlp_pkg::layer_hidden_base + 12'(k)), rd);
      check_word($sformatf("hidden weight %0d", k), rd[15:0], w_hid[k]);
    end
    for (int k = 0; k < c.num_hidden * c.num_outputs; k++) begin
      bus_read(weight_bus_addr(mlp_pkg::layer_output_base + 12'(k)), rd);
      check_word($sformatf("output weight %0d", k), rd[15:0], w_out[k]);
    end
  endtask

  task automatic run_engine(input mlp_pkg::mlp_cfg_t c, input bit saturate);
    logic [31:0] rd;
    load_run(c, saturate);
    compute_model(c);
    bus_write(reg_bus_addr(mlp_pkg::reg_control), 32'h0);
    bus_read(reg_bus_addr(mlp_pkg::reg_status), rd);
    check_word("status before start", rd[15:0], 16'h0000);
    bus_write(reg_bus_addr(mlp_pkg::reg_control), 32'(1) << mlp_pkg::ctrl_start_bit);
    do begin
      bus_read(reg_bus_addr(mlp_pkg::reg_status), rd);
    end while (rd[0] !== 1'b1);
    check_word("status at done", rd[15:0], 16'h0001);
    bus_write(reg_bus_addr(mlp_pkg::reg_control), 32'h0);
    bus_read(reg_bus_addr(mlp_pkg::reg_status), rd);
    check_word("status after start cleared", rd[15:0], 16'h0000);
    for (int n = 0; n < c.num_hidden; n++) begin
      bus_read(data_bus_addr(mlp_pkg::bank_hidden, 8'(n)), rd);
      check_data($sformatf("hidden %0d", n), rd[7:0], hid_exp[n]);
      if (saturate) begin
        check_data("clipped hidden", rd[7:0], lut_mem[(n == 0) ? 12'h7FF : 12'h800]);
      end
    end
    for (int o = 0; o < c.num_outputs; o++) begin
      bus_read(data_bus_addr(mlp_pkg::bank_output, 8'(o)), rd);
      check_data($sformatf("output %0d", o), rd[7:0], out_exp[o]);
    end
  endtask

  initial begin
    int unsigned       seed_init;
    mlp_pkg::mlp_cfg_t run_cfg;
    seed_init = $urandom(33168);
    rst_n   = 1'b0;
    address = '0;
    din     = '0;
    write   = 1'b0;
    read    = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    rst_n = 1'b1;

    repeat (8) begin
      run_cfg = mlp_cfg_t_random();
      write_counts(run_cfg);
    end

    bus_write(reg_bus_addr(mlp_pkg::reg_control), 32'(1) << mlp_pkg::ctrl_load_bit);
    fill_lut();

    for (int r = 0; r < num_runs; r++) begin
      run_cfg.num_inputs  = 8'(1 + $urandom % max_inputs);
      run_cfg.num_hidden  = 8'(1 + $urandom % max_hidden);
      run_cfg.num_outputs = 8'(1 + $urandom % max_outputs);
      run_engine(run_cfg, 1'b0);
    end

    run_cfg.num_inputs  = 8'd4;
    run_cfg.num_hidden  = 8'd2;
    run_cfg.num_outputs = 8'd1;
    run_engine(run_cfg, 1'b1);

    $display("PASS: all tests");
    $finish;
  end

  function automatic mlp_pkg::mlp_cfg_t mlp_cfg_t_random();
    mlp_pkg::mlp_cfg_t c;
    c.num_inputs  = 8'($urandom);
    c.num_hidden  = 8'($urandom);
    c.num_outputs = 8'($urandom);
    return c;
  endfunction

endmodule
